// ==== src/mem_access_pkg.sv ====
`default_nettype none

package mem_access_pkg;

    typedef logic [31:0] addr_t;    // axi byte address
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;    // one bit per data byte
    typedef logic [2:0]  size_t;    // axi size code
    typedef logic [1:0]  resp_t;
    typedef logic [3:0]  id_t;

    // owner of a transaction, carried through to the response
    typedef enum logic {
        SRC_DATA  = 1'b0,
        SRC_FETCH = 1'b1
    } req_src_e;

    localparam id_t   ID_DATA    = 4'd0;
    localparam id_t   ID_FETCH   = 4'd1;

    localparam size_t SIZE_DWORD = 3'b011;    // 8 bytes per beat
    localparam resp_t RESP_OKAY  = 2'b00;

    localparam logic [1:0] BURST_INCR = 2'b01;
    localparam logic [7:0] LEN_SINGLE = 8'd0;       // one beat per transfer
    localparam logic [3:0] CACHE_ATTR = 4'b0010;    // normal, non-cacheable
    localparam logic [2:0] PROT_ATTR  = 3'b000;     // unprivileged, secure

endpackage

`default_nettype wire

// ==== src/mem_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if;

    logic                     req_valid;
    logic                     req_ready;
    logic                     req_write;
    mem_access_pkg::addr_t    req_addr;
    mem_access_pkg::data_t    req_wdata;
    mem_access_pkg::strb_t    req_strb;
    mem_access_pkg::size_t    req_size;
    mem_access_pkg::req_src_e req_src;     // ends up in axi id

    logic                     rsp_valid;   // one cycle pulse, no backpressure
    mem_access_pkg::data_t    rsp_rdata;
    logic                     rsp_err;
    mem_access_pkg::req_src_e rsp_src;
    logic                     rsp_write;   // completed access was a write

    modport arbiter (
        output req_valid, req_write, req_addr, req_wdata, req_strb, req_size, req_src,
        input  req_ready, rsp_valid, rsp_rdata, rsp_err, rsp_src
    );

    modport bridge (
        input  req_valid, req_write, req_addr, req_wdata, req_strb, req_size, req_src,
        output req_ready, rsp_valid, rsp_rdata, rsp_err, rsp_src, rsp_write
    );

    modport monitor (
        input rsp_valid, rsp_err, rsp_src, rsp_write
    );

endinterface

`default_nettype wire

// ==== src/axi_rw_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rw_arbiter (
    input  logic                  clk,
    input  logic                  rst_i,
    // fetch port, read only
    input  logic                  fetch_valid_i,
    output logic                  fetch_ready_o,
    input  mem_access_pkg::addr_t fetch_addr_i,
    output logic                  fetch_rsp_valid_o,
    output mem_access_pkg::data_t fetch_rdata_o,
    output logic                  fetch_err_o,
    // data port
    input  logic                  data_valid_i,
    output logic                  data_ready_o,
    input  logic                  data_write_i,
    input  mem_access_pkg::addr_t data_addr_i,
    input  mem_access_pkg::data_t data_wdata_i,
    input  mem_access_pkg::strb_t data_strb_i,
    input  mem_access_pkg::size_t data_size_i,
    output logic                  data_rsp_valid_o,
    output mem_access_pkg::data_t data_rdata_o,
    output logic                  data_err_o,
    mem_req_if.arbiter            bus
);

    logic                     hold_q;       // request presented but not yet taken
    mem_access_pkg::req_src_e hold_src_q;
    mem_access_pkg::req_src_e grant;
    logic                     data_sel;
    logic                     fetch_rsp;
    logic                     data_rsp;

    // data wins a tie, unless a stalled grant is still pending
    always_comb begin
        if (hold_q) begin
            grant = hold_src_q;
        end else if (data_valid_i) begin
            grant = mem_access_pkg::SRC_DATA;
        end else begin
            grant = mem_access_pkg::SRC_FETCH;
        end
    end

    assign data_sel = (grant == mem_access_pkg::SRC_DATA);

    assign bus.req_valid = data_sel ? data_valid_i : fetch_valid_i;
    assign bus.req_write = data_sel && data_write_i;    // fetch only reads
    assign bus.req_addr  = data_sel ? data_addr_i : fetch_addr_i;
    assign bus.req_wdata = data_sel ? data_wdata_i : '0;
    assign bus.req_strb  = data_sel ? data_strb_i : '1;
    assign bus.req_size  = data_sel ? data_size_i : mem_access_pkg::SIZE_DWORD;
    assign bus.req_src   = grant;

    assign data_ready_o  = data_sel && bus.req_ready;
    assign fetch_ready_o = !data_sel && bus.req_ready;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            hold_q     <= 1'b0;
            hold_src_q <= mem_access_pkg::SRC_DATA;
        end else begin
            hold_q     <= bus.req_valid && !bus.req_ready;
            hold_src_q <= grant;
        end
    end

    // response goes back only to the port that owns it
    assign fetch_rsp = bus.rsp_valid && (bus.rsp_src == mem_access_pkg::SRC_FETCH);
    assign data_rsp  = bus.rsp_valid && (bus.rsp_src == mem_access_pkg::SRC_DATA);

    assign fetch_rsp_valid_o = fetch_rsp;
    assign fetch_rdata_o     = fetch_rsp ? bus.rsp_rdata : '0;
    assign fetch_err_o       = fetch_rsp && bus.rsp_err;

    assign data_rsp_valid_o  = data_rsp;
    assign data_rdata_o      = data_rsp ? bus.rsp_rdata : '0;
    assign data_err_o        = data_rsp && bus.rsp_err;

endmodule

`default_nettype wire

// ==== src/axi_master_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_master_bridge (
    input  logic                  clk,
    input  logic                  rst_i,
    mem_req_if.bridge             bus,
    // write address
    output logic                  awvalid_o,
    input  logic                  awready_i,
    output mem_access_pkg::addr_t awaddr_o,
    output mem_access_pkg::id_t   awid_o,
    output logic [7:0]            awlen_o,
    output mem_access_pkg::size_t awsize_o,
    output logic [1:0]            awburst_o,
    output logic                  awlock_o,
    output logic [3:0]            awcache_o,
    output logic [2:0]            awprot_o,
    output logic [3:0]            awqos_o,
    output logic [3:0]            awregion_o,
    // write data
    output logic                  wvalid_o,
    input  logic                  wready_i,
    output mem_access_pkg::data_t wdata_o,
    output mem_access_pkg::strb_t wstrb_o,
    output logic                  wlast_o,
    // write response
    input  logic                  bvalid_i,
    output logic                  bready_o,
    input  mem_access_pkg::resp_t bresp_i,
    input  mem_access_pkg::id_t   bid_i,
    // read address
    output logic                  arvalid_o,
    input  logic                  arready_i,
    output mem_access_pkg::addr_t araddr_o,
    output mem_access_pkg::id_t   arid_o,
    output logic [7:0]            arlen_o,
    output mem_access_pkg::size_t arsize_o,
    output logic [1:0]            arburst_o,
    output logic                  arlock_o,
    output logic [3:0]            arcache_o,
    output logic [2:0]            arprot_o,
    output logic [3:0]            arqos_o,
    output logic [3:0]            arregion_o,
    // read data
    input  logic                  rvalid_i,
    output logic                  rready_o,
    input  mem_access_pkg::data_t rdata_i,
    input  mem_access_pkg::resp_t rresp_i,
    input  logic                  rlast_i,
    input  mem_access_pkg::id_t   rid_i
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RADDR,
        ST_RDATA,
        ST_WADDR,    // aw and w in flight together
        ST_WRESP
    } state_e;

    state_e                   state_q;
    logic                     aw_done_q;
    logic                     w_done_q;
    logic                     rsp_valid_q;
    mem_access_pkg::addr_t    addr_q;
    mem_access_pkg::data_t    wdata_q;
    mem_access_pkg::strb_t    strb_q;
    mem_access_pkg::size_t    size_q;
    mem_access_pkg::req_src_e src_q;
    logic                     write_q;
    mem_access_pkg::data_t    rdata_q;
    logic                     err_q;
    mem_access_pkg::id_t      id_exp;
    logic                     aw_fin;
    logic                     w_fin;

    assign id_exp = (src_q == mem_access_pkg::SRC_FETCH) ? mem_access_pkg::ID_FETCH
                                                         : mem_access_pkg::ID_DATA;
    assign aw_fin = aw_done_q || (awvalid_o && awready_i);
    assign w_fin  = w_done_q || (wvalid_o && wready_i);

    assign bus.req_ready = (state_q == ST_IDLE);    // one transaction at a time
    assign bus.rsp_valid = rsp_valid_q;
    assign bus.rsp_rdata = rdata_q;
    assign bus.rsp_err   = err_q;
    assign bus.rsp_src   = src_q;
    assign bus.rsp_write = write_q;

    assign awvalid_o  = (state_q == ST_WADDR) && !aw_done_q;
    assign awaddr_o   = addr_q;
    assign awid_o     = id_exp;
    assign awlen_o    = mem_access_pkg::LEN_SINGLE;
    assign awsize_o   = size_q;
    assign awburst_o  = mem_access_pkg::BURST_INCR;
    assign awlock_o   = 1'b0;
    assign awcache_o  = mem_access_pkg::CACHE_ATTR;
    assign awprot_o   = mem_access_pkg::PROT_ATTR;
    assign awqos_o    = 4'd0;
    assign awregion_o = 4'd0;

    assign wvalid_o   = (state_q == ST_WADDR) && !w_done_q;
    assign wdata_o    = wdata_q;
    assign wstrb_o    = strb_q;
    assign wlast_o    = 1'b1;                        // single beat
    assign bready_o   = (state_q == ST_WRESP);

    assign arvalid_o  = (state_q == ST_RADDR);
    assign araddr_o   = addr_q;
    assign arid_o     = id_exp;
    assign arlen_o    = mem_access_pkg::LEN_SINGLE;
    assign arsize_o   = size_q;
    assign arburst_o  = mem_access_pkg::BURST_INCR;
    assign arlock_o   = 1'b0;
    assign arcache_o  = mem_access_pkg::CACHE_ATTR;
    assign arprot_o   = mem_access_pkg::PROT_ATTR;
    assign arqos_o    = 4'd0;
    assign arregion_o = 4'd0;
    assign rready_o   = (state_q == ST_RDATA);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= ST_IDLE;
            aw_done_q   <= 1'b0;
            w_done_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (bus.req_valid) begin
                        state_q <= bus.req_write ? ST_WADDR : ST_RADDR;
                    end
                end
                ST_RADDR: begin
                    if (arready_i) begin
                        state_q <= ST_RDATA;
                    end
                end
                ST_RDATA: begin
                    if (rvalid_i) begin
                        state_q     <= ST_IDLE;
                        rsp_valid_q <= 1'b1;
                    end
                end
                ST_WADDR: begin
                    if (aw_fin && w_fin) begin
                        state_q   <= ST_WRESP;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end else begin
                        aw_done_q <= aw_fin;    // remember whichever side is through
                        w_done_q  <= w_fin;
                    end
                end
                ST_WRESP: begin
                    if (bvalid_i) begin
                        state_q     <= ST_IDLE;
                        rsp_valid_q <= 1'b1;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // request and response payload
    always_ff @(posedge clk) begin
        if (bus.req_valid && bus.req_ready) begin
            addr_q  <= bus.req_addr;
            wdata_q <= bus.req_wdata;
            strb_q  <= bus.req_strb;
            size_q  <= bus.req_size;
            src_q   <= bus.req_src;
            write_q <= bus.req_write;
        end
        // a wrong id or missing last is reported like slverr
        if (rvalid_i && rready_o) begin
            rdata_q <= rdata_i;
            err_q   <= (rresp_i != mem_access_pkg::RESP_OKAY) || (rid_i != id_exp) || !rlast_i;
        end
        if (bvalid_i && bready_o) begin
            rdata_q <= '0;
            err_q   <= (bresp_i != mem_access_pkg::RESP_OKAY) || (bid_i != id_exp);
        end
    end

endmodule

`default_nettype wire

// ==== src/access_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module access_counters #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   rst_i,
    mem_req_if.monitor             bus,
    output logic [COUNT_WIDTH-1:0] fetch_count_o,
    output logic [COUNT_WIDTH-1:0] data_read_count_o,
    output logic [COUNT_WIDTH-1:0] data_write_count_o,
    output logic [COUNT_WIDTH-1:0] error_count_o
);

    logic [3:0]             hit;           // fetch, data read, data write, error
    logic [COUNT_WIDTH-1:0] count_q [4];

    always_comb begin
        hit[0] = bus.rsp_valid && (bus.rsp_src == mem_access_pkg::SRC_FETCH);
        hit[1] = bus.rsp_valid && (bus.rsp_src == mem_access_pkg::SRC_DATA) && !bus.rsp_write;
        hit[2] = bus.rsp_valid && (bus.rsp_src == mem_access_pkg::SRC_DATA) && bus.rsp_write;
        hit[3] = bus.rsp_valid && bus.rsp_err;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (rst_i) begin
                count_q[i] <= '0;
            end else if (hit[i]) begin
                count_q[i] <= count_q[i] + COUNT_WIDTH'(1);    // wraps
            end
        end
    end

    assign fetch_count_o      = count_q[0];
    assign data_read_count_o  = count_q[1];
    assign data_write_count_o = count_q[2];
    assign error_count_o      = count_q[3];

endmodule

`default_nettype wire

// ==== src/mem_access_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_top #(
    parameter int COUNT_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   rst_i,
    // fetch port
    input  logic                   fetch_valid_i,
    output logic                   fetch_ready_o,
    input  mem_access_pkg::addr_t  fetch_addr_i,
    output logic                   fetch_rsp_valid_o,
    output mem_access_pkg::data_t  fetch_rdata_o,
    output logic                   fetch_err_o,
    // data port
    input  logic                   data_valid_i,
    output logic                   data_ready_o,
    input  logic                   data_write_i,
    input  mem_access_pkg::addr_t  data_addr_i,
    input  mem_access_pkg::data_t  data_wdata_i,
    input  mem_access_pkg::strb_t  data_strb_i,
    input  mem_access_pkg::size_t  data_size_i,
    output logic                   data_rsp_valid_o,
    output mem_access_pkg::data_t  data_rdata_o,
    output logic                   data_err_o,
    // axi4 master
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output mem_access_pkg::addr_t  awaddr_o,
    output mem_access_pkg::id_t    awid_o,
    output logic [7:0]             awlen_o,
    output mem_access_pkg::size_t  awsize_o,
    output logic [1:0]             awburst_o,
    output logic                   awlock_o,
    output logic [3:0]             awcache_o,
    output logic [2:0]             awprot_o,
    output logic [3:0]             awqos_o,
    output logic [3:0]             awregion_o,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    output mem_access_pkg::data_t  wdata_o,
    output mem_access_pkg::strb_t  wstrb_o,
    output logic                   wlast_o,
    input  logic                   bvalid_i,
    output logic                   bready_o,
    input  mem_access_pkg::resp_t  bresp_i,
    input  mem_access_pkg::id_t    bid_i,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    output mem_access_pkg::addr_t  araddr_o,
    output mem_access_pkg::id_t    arid_o,
    output logic [7:0]             arlen_o,
    output mem_access_pkg::size_t  arsize_o,
    output logic [1:0]             arburst_o,
    output logic                   arlock_o,
    output logic [3:0]             arcache_o,
    output logic [2:0]             arprot_o,
    output logic [3:0]             arqos_o,
    output logic [3:0]             arregion_o,
    input  logic                   rvalid_i,
    output logic                   rready_o,
    input  mem_access_pkg::data_t  rdata_i,
    input  mem_access_pkg::resp_t  rresp_i,
    input  logic                   rlast_i,
    input  mem_access_pkg::id_t    rid_i,
    // completed access counts
    output logic [COUNT_WIDTH-1:0] fetch_count_o,
    output logic [COUNT_WIDTH-1:0] data_read_count_o,
    output logic [COUNT_WIDTH-1:0] data_write_count_o,
    output logic [COUNT_WIDTH-1:0] error_count_o
);

    mem_req_if req_bus ();    // arbiter to bridge, bridge to counters

    // port names match the top level, so the rest connects by name
    axi_rw_arbiter u_arbiter (
        .bus (req_bus),
        .*
    );

    axi_master_bridge u_bridge (
        .bus (req_bus),
        .*
    );

    access_counters #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_counters (
        .bus (req_bus),
        .*
    );

endmodule

`default_nettype wire

// ==== testbench/mem_access_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access_properties (
    input  logic                  clk,
    input  logic                  rst_i,
    input  logic                  arvalid_o,
    input  logic                  arready_i,
    input  mem_access_pkg::addr_t araddr_o,
    input  mem_access_pkg::size_t arsize_o,
    input  logic [7:0]            arlen_o,
    input  logic [1:0]            arburst_o,
    input  logic                  rvalid_i,
    input  logic                  rready_o,
    input  logic                  awvalid_o,
    input  logic                  awready_i,
    input  mem_access_pkg::addr_t awaddr_o,
    input  mem_access_pkg::size_t awsize_o,
    input  logic [7:0]            awlen_o,
    input  logic [1:0]            awburst_o,
    input  logic                  wvalid_o,
    input  logic                  wready_i,
    input  mem_access_pkg::data_t wdata_o,
    input  mem_access_pkg::strb_t wstrb_o,
    input  logic                  bvalid_i,
    input  logic                  bready_o
);

    logic [1:0] open_q;    // address beats sent and not yet answered

    always_ff @(posedge clk) begin
        if (rst_i) begin
            open_q <= 2'd0;
        end else if ((arvalid_o && arready_i) || (awvalid_o && awready_i)) begin
            open_q <= open_q + 2'd1;
        end else if ((rvalid_i && rready_o) || (bvalid_i && bready_o)) begin
            open_q <= open_q - 2'd1;
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (rst_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o) && $stable(arsize_o))
        else $error("ar channel changed while stalled");

    a_aw_stable: assert property (@(posedge clk) disable iff (rst_i)
        awvalid_o && !awready_i |=> awvalid_o && $stable(awaddr_o) && $stable(awsize_o))
        else $error("aw channel changed while stalled");

    a_w_stable: assert property (@(posedge clk) disable iff (rst_i)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o) && $stable(wstrb_o))
        else $error("w channel changed while stalled");

    a_ar_single_beat: assert property (@(posedge clk) disable iff (rst_i)
        arvalid_o |-> arlen_o == 8'd0 && arburst_o == mem_access_pkg::BURST_INCR)
        else $error("read address beat is not a single incr beat");

    a_aw_single_beat: assert property (@(posedge clk) disable iff (rst_i)
        awvalid_o |-> awlen_o == 8'd0 && awburst_o == mem_access_pkg::BURST_INCR)
        else $error("write address beat is not a single incr beat");

    // no new address beat until the previous one got its response
    a_one_outstanding: assert property (@(posedge clk) disable iff (rst_i)
        (arvalid_o || awvalid_o) |-> open_q == 2'd0)
        else $error("more than one transaction outstanding");

endmodule

bind axi_master_bridge mem_access_properties u_props (.*);

`default_nettype wire

// ==== testbench/tb_mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_access;

    localparam int COUNT_WIDTH = 32;
    localparam int OPS = 200;
    localparam int CYCLE_LIMIT = OPS * 20;
    localparam mem_access_pkg::addr_t ERR_BASE = 32'h8000_0000;
    localparam mem_access_pkg::resp_t RESP_SLVERR = 2'b10;

    logic clk;
    logic rst_i;
    logic fetch_valid_i, fetch_ready_o, fetch_rsp_valid_o, fetch_err_o;
    mem_access_pkg::addr_t fetch_addr_i;
    mem_access_pkg::data_t fetch_rdata_o;
    logic data_valid_i, data_ready_o, data_write_i, data_rsp_valid_o, data_err_o;
    mem_access_pkg::addr_t data_addr_i;
    mem_access_pkg::data_t data_wdata_i, data_rdata_o;
    mem_access_pkg::strb_t data_strb_i;
    mem_access_pkg::size_t data_size_i;
    logic awvalid_o, awready_i, awlock_o, wvalid_o, wready_i, wlast_o;
    mem_access_pkg::addr_t awaddr_o, araddr_o;
    mem_access_pkg::id_t awid_o, bid_i, arid_o, rid_i;
    logic [7:0] awlen_o, arlen_o;
    mem_access_pkg::size_t awsize_o, arsize_o;
    logic [1:0] awburst_o, arburst_o;
    logic [3:0] awcache_o, awqos_o, awregion_o, arcache_o, arqos_o, arregion_o;
    logic [2:0] awprot_o, arprot_o;
    mem_access_pkg::data_t wdata_o, rdata_i;
    mem_access_pkg::strb_t wstrb_o;
    logic bvalid_i, bready_o, arvalid_o, arready_i, arlock_o, rvalid_i, rready_o, rlast_i;
    mem_access_pkg::resp_t bresp_i, rresp_i;
    logic [COUNT_WIDTH-1:0] fetch_count_o, data_read_count_o;
    logic [COUNT_WIDTH-1:0] data_write_count_o, error_count_o;

    integer seed = 32'h22ff_6344;
    int cycles = 0;
    int fetch_tally = 0;
    int read_tally = 0;
    int write_tally = 0;
    int err_tally = 0;
    mem_access_pkg::data_t slv_mem [logic [28:0]];    // slave storage, per dword
    mem_access_pkg::data_t ref_mem [logic [28:0]];    // expected contents
    mem_access_pkg::addr_t addr_log [$];              // address beats in bus order
    mem_access_pkg::size_t size_log [$];
    mem_access_pkg::id_t   id_log [$];

    mem_access_top #(.COUNT_WIDTH(COUNT_WIDTH)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: operations did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $fatal(1);
        end
    end

    function automatic mem_access_pkg::data_t fill_word(input mem_access_pkg::addr_t a);
        return {a ^ 32'h5a5a_0f0f, a};    // unwritten memory
    endfunction

    function automatic mem_access_pkg::data_t ref_read(input mem_access_pkg::addr_t a);
        if (ref_mem.exists(a[31:3])) return ref_mem[a[31:3]];
        return fill_word(a);
    endfunction

    function automatic mem_access_pkg::data_t merge_bytes(input mem_access_pkg::data_t old,
            input mem_access_pkg::data_t wd, input mem_access_pkg::strb_t st);
        mem_access_pkg::data_t res;
        res = old;
        for (int i = 0; i < 8; i++) begin
            if (st[i]) res[i*8 +: 8] = wd[i*8 +: 8];
        end
        return res;
    endfunction

    function automatic int rand_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    function automatic mem_access_pkg::addr_t pick_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] == 3'd0) return ERR_BASE | {21'd0, r[10:3], 3'b000};
        return 32'h0000_1000 | {24'd0, r[10:6], 3'b000};    // small set, so reads hit writes
    endfunction

    task automatic report_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("error: %s expected %h actual %h", name, exp, act);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input mem_access_pkg::data_t exp,
            input mem_access_pkg::data_t act);
        if (act !== exp) report_value(name, exp, act);
    endtask

    task automatic check_resp(input string name, input logic exp, input logic act);
        if (act !== exp) report_value(name, 64'(exp), 64'(act));
    endtask

    task automatic check_addr(input string name, input mem_access_pkg::addr_t exp,
            input mem_access_pkg::addr_t act);
        if (act !== exp) report_value(name, 64'(exp), 64'(act));
    endtask

    task automatic check_size(input string name, input mem_access_pkg::size_t exp,
            input mem_access_pkg::size_t act);
        if (act !== exp) report_value(name, 64'(exp), 64'(act));
    endtask

    task automatic check_id(input string name, input mem_access_pkg::id_t exp,
            input mem_access_pkg::id_t act);
        if (act !== exp) report_value(name, 64'(exp), 64'(act));
    endtask

    // lock, cache, prot, qos and region packed together
    task automatic check_attr(input string name, input logic [15:0] exp,
            input logic [15:0] act);
        if (act !== exp) report_value(name, 64'(exp), 64'(act));
    endtask

    task automatic check_count(input string name, input logic [COUNT_WIDTH-1:0] exp,
            input logic [COUNT_WIDTH-1:0] act);
        if (act !== exp) report_value(name, 64'(exp), 64'(act));
    endtask

    // single transaction slave, the bridge never has two in flight
    initial begin : axi_slave
        mem_access_pkg::addr_t a;
        mem_access_pkg::id_t id;
        mem_access_pkg::data_t wd;
        mem_access_pkg::strb_t st;
        forever begin
            @(negedge clk);
            if (arvalid_o) begin
                a = araddr_o;
                id = arid_o;
                addr_log.push_back(a);
                size_log.push_back(arsize_o);
                id_log.push_back(id);
                check_attr("ar attributes",
                    {1'b0, mem_access_pkg::CACHE_ATTR, mem_access_pkg::PROT_ATTR, 8'h00},
                    {arlock_o, arcache_o, arprot_o, arqos_o, arregion_o});
                repeat (rand_delay()) @(negedge clk);
                arready_i = 1'b1;
                @(negedge clk);
                arready_i = 1'b0;
                repeat (rand_delay()) @(negedge clk);
                rvalid_i = 1'b1;
                rid_i = id;
                rresp_i = (a >= ERR_BASE) ? RESP_SLVERR : mem_access_pkg::RESP_OKAY;
                rdata_i = '0;
                if (a < ERR_BASE) begin
                    rdata_i = slv_mem.exists(a[31:3]) ? slv_mem[a[31:3]] : fill_word(a);
                end
                check_resp("rready in data phase", 1'b1, rready_o);
                @(negedge clk);    // rready already high in the data phase
                rvalid_i = 1'b0;
            end else if (awvalid_o) begin
                a = awaddr_o;
                id = awid_o;
                wd = wdata_o;
                st = wstrb_o;
                addr_log.push_back(a);
                size_log.push_back(awsize_o);
                id_log.push_back(id);
                check_attr("aw attributes",
                    {1'b0, mem_access_pkg::CACHE_ATTR, mem_access_pkg::PROT_ATTR, 8'h00},
                    {awlock_o, awcache_o, awprot_o, awqos_o, awregion_o});
                check_resp("wlast", 1'b1, wlast_o);
                repeat (rand_delay()) @(negedge clk);
                awready_i = 1'b1;
                wready_i = 1'b1;
                @(negedge clk);
                awready_i = 1'b0;
                wready_i = 1'b0;
                if (a < ERR_BASE) begin
                    slv_mem[a[31:3]] = merge_bytes(
                        slv_mem.exists(a[31:3]) ? slv_mem[a[31:3]] : fill_word(a), wd, st);
                end
                repeat (rand_delay()) @(negedge clk);
                bvalid_i = 1'b1;
                bid_i = id;
                bresp_i = (a >= ERR_BASE) ? RESP_SLVERR : mem_access_pkg::RESP_OKAY;
                check_resp("bready in response phase", 1'b1, bready_o);
                @(negedge clk);
                bvalid_i = 1'b0;
            end
        end
    end

    task automatic issue_data(input logic wr, input mem_access_pkg::addr_t a,
            input mem_access_pkg::data_t wd, input mem_access_pkg::strb_t st,
            input mem_access_pkg::size_t sz);
        mem_access_pkg::data_t exp;
        logic exp_err;
        exp_err = (a >= ERR_BASE);
        exp = ref_read(a);
        data_valid_i = 1'b1;
        data_write_i = wr;
        data_addr_i = a;
        data_wdata_i = wd;
        data_strb_i = st;
        data_size_i = sz;
        #1;
        while (!data_ready_o) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        data_valid_i = 1'b0;
        while (!data_rsp_valid_o) @(negedge clk);
        check_id("data id", mem_access_pkg::ID_DATA, id_log[$]);
        check_resp("data err", exp_err, data_err_o);
        check_resp("fetch err on data response", 1'b0, fetch_err_o);
        if (!wr && !exp_err) check_data("data read", exp, data_rdata_o);
        if (wr && !exp_err) ref_mem[a[31:3]] = merge_bytes(exp, wd, st);
        if (wr) write_tally++;
        else read_tally++;
        if (exp_err) err_tally++;
    endtask

    task automatic issue_fetch(input mem_access_pkg::addr_t a);
        logic exp_err;
        exp_err = (a >= ERR_BASE);
        fetch_valid_i = 1'b1;
        fetch_addr_i = a;
        #1;
        while (!fetch_ready_o) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        fetch_valid_i = 1'b0;
        while (!fetch_rsp_valid_o) @(negedge clk);
        check_id("fetch id", mem_access_pkg::ID_FETCH, id_log[$]);
        check_size("fetch size", mem_access_pkg::SIZE_DWORD, size_log[$]);
        check_resp("fetch err", exp_err, fetch_err_o);
        check_resp("data err on fetch response", 1'b0, data_err_o);
        if (!exp_err) check_data("fetch read", ref_read(a), fetch_rdata_o);
        fetch_tally++;
        if (exp_err) err_tally++;
    endtask

    initial begin
        mem_access_pkg::addr_t a;
        mem_access_pkg::addr_t b;
        mem_access_pkg::data_t wd;
        mem_access_pkg::strb_t st;
        mem_access_pkg::size_t sz;
        int kind;
        rst_i = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_addr_i = '0;
        data_valid_i = 1'b0;
        data_write_i = 1'b0;
        data_addr_i = '0;
        data_wdata_i = '0;
        data_strb_i = '0;
        data_size_i = '0;
        {awready_i, wready_i, bvalid_i, arready_i, rvalid_i} = '0;
        bresp_i = '0;
        bid_i = '0;
        rdata_i = '0;
        rresp_i = '0;
        rlast_i = 1'b1;
        rid_i = '0;
        repeat (10) @(negedge clk);
        rst_i = 1'b0;
        for (int op = 0; op < OPS; op++) begin
            kind = $unsigned($random(seed)) % 4;
            a = pick_addr();
            b = pick_addr();
            wd = {$random(seed), $random(seed)};
            st = mem_access_pkg::strb_t'($random(seed));
            sz = mem_access_pkg::size_t'($unsigned($random(seed)) % 4);
            addr_log.delete();
            size_log.delete();
            id_log.delete();
            case (kind)
                0: issue_fetch(a);
                1: begin
                    issue_data(1'b1, a, wd, st, sz);
                    check_size("aw size", sz, size_log[0]);
                    issue_data(1'b0, a, '0, '0, sz);
                    check_size("ar size", sz, size_log[1]);
                end
                2: begin
                    fork    // both valid in the same cycle
                        issue_data(1'b0, a, '0, '0, sz);
                        issue_fetch(b);
                    join
                    check_addr("first address beat", a, addr_log[0]);
                    check_addr("second address beat", b, addr_log[1]);
                end
                default: issue_data(1'b0, a, '0, '0, sz);
            endcase
        end
        repeat (3) @(negedge clk);
        check_count("fetch count", COUNT_WIDTH'(fetch_tally), fetch_count_o);
        check_count("data read count", COUNT_WIDTH'(read_tally), data_read_count_o);
        check_count("data write count", COUNT_WIDTH'(write_tally), data_write_count_o);
        check_count("error count", COUNT_WIDTH'(err_tally), error_count_o);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
src/mem_access_pkg.sv
src/mem_req_if.sv
src/axi_rw_arbiter.sv
src/axi_master_bridge.sv
src/access_counters.sv
src/mem_access_top.sv
testbench/mem_access_properties.sv
testbench/tb_mem_access.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_mem_access
RTL_TOP    ?= mem_access_top
FILELIST   ?= flist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		src/mem_access_pkg.sv src/mem_req_if.sv src/axi_rw_arbiter.sv \
		src/axi_master_bridge.sv src/access_counters.sv src/mem_access_top.sv

clean:
	rm -rf $(OBJ_DIR)
